// ==== include/lce_consts.svh ====
// lce geometry constants
`ifndef LCE_CONSTS_SVH
`define LCE_CONSTS_SVH

// cache organization
`define LCE_ASSOC        2
`define LCE_WAY_WIDTH    1
`define LCE_SETS         4
`define LCE_INDEX_WIDTH  2

// block and address layout
`define LCE_BLOCK_WIDTH  64
`define LCE_OFFSET_WIDTH 3
`define LCE_PADDR_WIDTH  16
// address bits above offset and index
`define LCE_TAG_WIDTH    11

// directories that must sync before operation
`define LCE_NUM_CCE      2
`define LCE_CCE_ID_WIDTH 1

// covers both the set sweep and the sync count
`define LCE_CNT_WIDTH    3

`endif

// ==== design/lce_pkg.sv ====
// lce command handler types
`include "lce_consts.svh"

package lce_pkg;

  // inbound command types
  typedef enum logic [3:0] {
    e_cmd_sync,
    e_cmd_set_clear,
    e_cmd_inv,
    e_cmd_st,
    e_cmd_data,
    e_cmd_st_wakeup,
    e_cmd_wb,
    e_cmd_st_wb,
    e_cmd_uc_st_done
  } lce_cmd_type_e;

  // outbound response types
  typedef enum logic [2:0] {
    e_resp_sync_ack,
    e_resp_inv_ack,
    e_resp_coh_ack,
    e_resp_null_wb,
    e_resp_wb
  } lce_resp_type_e;

  // invalid must stay at zero, cleared tags read back as I
  typedef enum logic [2:0] {
    e_coh_i = 3'd0,
    e_coh_s,
    e_coh_e,
    e_coh_f,
    e_coh_m,
    e_coh_o
  } coh_state_e;

  typedef enum logic [1:0] {e_tag_set_clear, e_tag_set_state, e_tag_set_tag} tag_op_e;
  typedef enum logic [1:0] {e_stat_set_clear, e_stat_read, e_stat_clear_dirty} stat_op_e;
  typedef enum logic {e_data_read, e_data_write} data_op_e;

  typedef logic [`LCE_BLOCK_WIDTH-1:0] lce_block_t;
  // one dirty bit per way
  typedef logic [`LCE_ASSOC-1:0] lce_stat_t;
  typedef logic [`LCE_CNT_WIDTH-1:0] lce_cnt_t;

endpackage

// ==== design/lce_read_buf.sv ====
// memory read capture buffer
module lce_read_buf
  import lce_pkg::*;
#(
  parameter type payload_t = lce_block_t
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     read_accept_i,
  input  payload_t rdata_i,
  output payload_t buf_o,
  output logic     buf_v_o
);

  logic load_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      load_r  <= 1'b0;
      buf_v_o <= 1'b0;
    end else begin
      load_r <= read_accept_i;
      // a new accept drops the flag before the reload sets it again
      buf_v_o <= (buf_v_o | load_r) & ~read_accept_i;
    end
  end

  // read data is only valid the cycle after the accept
  always_ff @(posedge clk_i) begin
    if (load_r) begin
      buf_o <= rdata_i;
    end
  end

endmodule

// ==== design/lce_sweep_counter.sv ====
// set sweep and sync counter
module lce_sweep_counter
  import lce_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     cnt_clear_i,
  input  logic     cnt_inc_i,
  input  logic     sync_done_clear_i,
  input  logic     sync_done_set_i,
  output lce_cnt_t cnt_o,
  output logic     sync_done_o
);

  // clear wins over increment
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_o <= '0;
    end else if (cnt_clear_i) begin
      cnt_o <= '0;
    end else if (cnt_inc_i) begin
      cnt_o <= cnt_o + 1'b1;
    end
  end

  // high once every directory has been acked
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync_done_o <= 1'b0;
    end else if (sync_done_clear_i) begin
      sync_done_o <= 1'b0;
    end else if (sync_done_set_i) begin
      sync_done_o <= 1'b1;
    end
  end

endmodule

// ==== design/lce_cmd_fsm.sv ====
// lce command processing fsm
`include "lce_consts.svh"

module lce_cmd_fsm
  import lce_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         lce_cmd_v_i,
  input  lce_cmd_type_e                lce_cmd_type_i,
  input  logic [`LCE_PADDR_WIDTH-1:0]  lce_cmd_addr_i,
  input  logic [`LCE_CCE_ID_WIDTH-1:0] lce_cmd_src_id_i,
  input  logic [`LCE_WAY_WIDTH-1:0]    lce_cmd_way_i,
  input  coh_state_e                   lce_cmd_state_i,
  input  lce_block_t                   lce_cmd_data_i,
  output logic                         lce_cmd_yumi_o,
  input  logic                         lce_resp_ready_i,
  output logic                         lce_resp_v_o,
  output lce_resp_type_e               lce_resp_type_o,
  output logic [`LCE_PADDR_WIDTH-1:0]  lce_resp_addr_o,
  output logic [`LCE_CCE_ID_WIDTH-1:0] lce_resp_dst_id_o,
  output lce_block_t                   lce_resp_data_o,
  output logic                         tag_mem_v_o,
  output tag_op_e                      tag_mem_op_o,
  output logic [`LCE_INDEX_WIDTH-1:0]  tag_mem_index_o,
  output logic [`LCE_WAY_WIDTH-1:0]    tag_mem_way_o,
  output coh_state_e                   tag_mem_state_o,
  output logic [`LCE_TAG_WIDTH-1:0]    tag_mem_tag_o,
  input  logic                         tag_mem_yumi_i,
  output logic                         stat_mem_v_o,
  output stat_op_e                     stat_mem_op_o,
  output logic [`LCE_INDEX_WIDTH-1:0]  stat_mem_index_o,
  output logic [`LCE_WAY_WIDTH-1:0]    stat_mem_way_o,
  input  logic                         stat_mem_yumi_i,
  output logic                         data_mem_v_o,
  output data_op_e                     data_mem_op_o,
  output logic [`LCE_INDEX_WIDTH-1:0]  data_mem_index_o,
  output logic [`LCE_WAY_WIDTH-1:0]    data_mem_way_o,
  output lce_block_t                   data_mem_data_o,
  input  logic                         data_mem_yumi_i,
  output logic                         cache_req_complete_o,
  output logic                         uc_store_req_complete_o,
  input  lce_cnt_t                     cnt_o,
  output logic                         cnt_clear_o,
  output logic                         cnt_inc_o,
  output logic                         sync_done_clear_o,
  output logic                         sync_done_set_o,
  input  lce_block_t                   data_buf_i,
  input  logic                         data_buf_v_i,
  input  lce_stat_t                    stat_buf_i,
  input  logic                         stat_buf_v_i,
  output logic                         ready_o
);

  typedef enum logic [2:0] {
    e_reset, e_clear, e_ready, e_coh_ack, e_wb, e_wb_dirty_rd, e_wb_dirty_send
  } fsm_state_e;

  fsm_state_e state_r, state_n;
  logic [`LCE_INDEX_WIDTH-1:0] cmd_index;
  logic [`LCE_TAG_WIDTH-1:0]   cmd_tag;
  logic                        way_dirty;

  assign cmd_index = lce_cmd_addr_i[`LCE_OFFSET_WIDTH +: `LCE_INDEX_WIDTH];
  assign cmd_tag   = lce_cmd_addr_i[`LCE_PADDR_WIDTH-1 -: `LCE_TAG_WIDTH];
  assign way_dirty = stat_buf_i[lce_cmd_way_i];

  // usable once the tag and stat sweep is over
  assign ready_o = (state_r != e_reset) && (state_r != e_clear);

  always_comb begin
    state_n = state_r;
    lce_cmd_yumi_o = 1'b0;
    cache_req_complete_o = 1'b0;
    uc_store_req_complete_o = 1'b0;
    cnt_clear_o = 1'b0;
    cnt_inc_o = 1'b0;
    sync_done_clear_o = 1'b0;
    sync_done_set_o = 1'b0;
    // responses always go back to the directory that sent the command
    lce_resp_v_o = 1'b0;
    lce_resp_type_o = e_resp_sync_ack;
    lce_resp_addr_o = lce_cmd_addr_i;
    lce_resp_dst_id_o = lce_cmd_src_id_i;
    lce_resp_data_o = '0;
    // packet fields follow the command unless a state overrides them
    tag_mem_v_o = 1'b0;
    tag_mem_op_o = e_tag_set_state;
    tag_mem_index_o = cmd_index;
    tag_mem_way_o = lce_cmd_way_i;
    tag_mem_state_o = lce_cmd_state_i;
    tag_mem_tag_o = cmd_tag;
    stat_mem_v_o = 1'b0;
    stat_mem_op_o = e_stat_read;
    stat_mem_index_o = cmd_index;
    stat_mem_way_o = lce_cmd_way_i;
    data_mem_v_o = 1'b0;
    data_mem_op_o = e_data_read;
    data_mem_index_o = cmd_index;
    data_mem_way_o = lce_cmd_way_i;
    data_mem_data_o = lce_cmd_data_i;

    unique case (state_r)
      e_reset: begin
        sync_done_clear_o = 1'b1;
        cnt_clear_o = 1'b1;
        state_n = e_clear;
      end

      // sweep every set, tag and stat together
      e_clear: begin
        tag_mem_v_o = 1'b1;
        tag_mem_op_o = e_tag_set_clear;
        tag_mem_index_o = cnt_o[`LCE_INDEX_WIDTH-1:0];
        tag_mem_state_o = e_coh_i;
        tag_mem_tag_o = '0;
        stat_mem_v_o = 1'b1;
        stat_mem_op_o = e_stat_set_clear;
        stat_mem_index_o = cnt_o[`LCE_INDEX_WIDTH-1:0];
        if (tag_mem_yumi_i && stat_mem_yumi_i) begin
          if (cnt_o == lce_cnt_t'(`LCE_SETS-1)) begin
            cnt_clear_o = 1'b1;
            state_n = e_ready;
          end else begin
            cnt_inc_o = 1'b1;
          end
        end
      end

      e_ready: begin
        if (lce_cmd_v_i) begin
          case (lce_cmd_type_i)
            e_cmd_sync: begin
              lce_resp_v_o = lce_resp_ready_i;
              lce_cmd_yumi_o = lce_resp_v_o;
              // last directory acked, so restart the count for next time
              cnt_clear_o = lce_resp_v_o && (cnt_o == lce_cnt_t'(`LCE_NUM_CCE-1));
              cnt_inc_o = lce_resp_v_o && !cnt_clear_o;
              sync_done_set_o = cnt_clear_o;
            end
            e_cmd_set_clear: begin
              tag_mem_v_o = 1'b1;
              tag_mem_op_o = e_tag_set_clear;
              stat_mem_v_o = 1'b1;
              stat_mem_op_o = e_stat_set_clear;
              lce_cmd_yumi_o = tag_mem_yumi_i && stat_mem_yumi_i;
            end
            e_cmd_inv: begin
              // hold the packet back until the ack can go out with it
              tag_mem_v_o = lce_resp_ready_i;
              tag_mem_state_o = e_coh_i;
              lce_resp_v_o = tag_mem_yumi_i && lce_resp_ready_i;
              lce_resp_type_o = e_resp_inv_ack;
              lce_cmd_yumi_o = lce_resp_v_o;
            end
            e_cmd_st: begin
              tag_mem_v_o = 1'b1;
              lce_cmd_yumi_o = tag_mem_yumi_i;
            end
            // miss fill writes block, tag and state at once
            e_cmd_data: begin
              data_mem_v_o = 1'b1;
              data_mem_op_o = e_data_write;
              tag_mem_v_o = 1'b1;
              tag_mem_op_o = e_tag_set_tag;
              if (tag_mem_yumi_i && data_mem_yumi_i) state_n = e_coh_ack;
            end
            e_cmd_st_wakeup: begin
              tag_mem_v_o = 1'b1;
              if (tag_mem_yumi_i) state_n = e_coh_ack;
            end
            e_cmd_wb: begin
              stat_mem_v_o = 1'b1;
              if (stat_mem_yumi_i) state_n = e_wb;
            end
            e_cmd_st_wb: begin
              tag_mem_v_o = 1'b1;
              stat_mem_v_o = 1'b1;
              if (tag_mem_yumi_i && stat_mem_yumi_i) state_n = e_wb;
            end
            e_cmd_uc_st_done: begin
              lce_cmd_yumi_o = 1'b1;
              uc_store_req_complete_o = 1'b1;
            end
            default: begin
            end
          endcase
        end
      end

      e_coh_ack: begin
        lce_resp_v_o = lce_cmd_v_i && lce_resp_ready_i;
        lce_resp_type_o = e_resp_coh_ack;
        lce_cmd_yumi_o = lce_resp_v_o;
        cache_req_complete_o = lce_resp_v_o;
        if (lce_resp_v_o) state_n = e_ready;
      end

      // wait for the dirty bits and finish here on a clean way
      e_wb: begin
        lce_resp_v_o = lce_resp_ready_i && stat_buf_v_i && !way_dirty;
        lce_resp_type_o = e_resp_null_wb;
        lce_cmd_yumi_o = lce_resp_v_o;
        if (stat_buf_v_i && way_dirty) begin
          state_n = e_wb_dirty_rd;
        end else if (lce_resp_v_o) begin
          state_n = e_ready;
        end
      end

      e_wb_dirty_rd: begin
        data_mem_v_o = 1'b1;
        stat_mem_v_o = 1'b1;
        stat_mem_op_o = e_stat_clear_dirty;
        if (data_mem_yumi_i && stat_mem_yumi_i) state_n = e_wb_dirty_send;
      end

      e_wb_dirty_send: begin
        lce_resp_v_o = lce_resp_ready_i && data_buf_v_i;
        lce_resp_type_o = e_resp_wb;
        lce_resp_data_o = data_buf_i;
        lce_cmd_yumi_o = lce_resp_v_o;
        if (lce_resp_v_o) state_n = e_ready;
      end

      default: begin
        state_n = e_reset;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_reset;
    end else begin
      state_r <= state_n;
    end
  end

endmodule

// ==== design/lce_cmd_top.sv ====
// lce command handler top
`include "lce_consts.svh"

module lce_cmd_top
  import lce_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         lce_cmd_v_i,
  input  lce_cmd_type_e                lce_cmd_type_i,
  input  logic [`LCE_PADDR_WIDTH-1:0]  lce_cmd_addr_i,
  input  logic [`LCE_CCE_ID_WIDTH-1:0] lce_cmd_src_id_i,
  input  logic [`LCE_WAY_WIDTH-1:0]    lce_cmd_way_i,
  input  coh_state_e                   lce_cmd_state_i,
  input  lce_block_t                   lce_cmd_data_i,
  output logic                         lce_cmd_yumi_o,
  input  logic                         lce_resp_ready_i,
  output logic                         lce_resp_v_o,
  output lce_resp_type_e               lce_resp_type_o,
  output logic [`LCE_PADDR_WIDTH-1:0]  lce_resp_addr_o,
  output logic [`LCE_CCE_ID_WIDTH-1:0] lce_resp_dst_id_o,
  output lce_block_t                   lce_resp_data_o,
  output logic                         tag_mem_v_o,
  output tag_op_e                      tag_mem_op_o,
  output logic [`LCE_INDEX_WIDTH-1:0]  tag_mem_index_o,
  output logic [`LCE_WAY_WIDTH-1:0]    tag_mem_way_o,
  output coh_state_e                   tag_mem_state_o,
  output logic [`LCE_TAG_WIDTH-1:0]    tag_mem_tag_o,
  input  logic                         tag_mem_yumi_i,
  output logic                         stat_mem_v_o,
  output stat_op_e                     stat_mem_op_o,
  output logic [`LCE_INDEX_WIDTH-1:0]  stat_mem_index_o,
  output logic [`LCE_WAY_WIDTH-1:0]    stat_mem_way_o,
  input  logic                         stat_mem_yumi_i,
  input  lce_stat_t                    stat_mem_i,
  output logic                         data_mem_v_o,
  output data_op_e                     data_mem_op_o,
  output logic [`LCE_INDEX_WIDTH-1:0]  data_mem_index_o,
  output logic [`LCE_WAY_WIDTH-1:0]    data_mem_way_o,
  output lce_block_t                   data_mem_data_o,
  input  logic                         data_mem_yumi_i,
  input  lce_block_t                   data_mem_i,
  output logic                         ready_o,
  output logic                         sync_done_o,
  output logic                         cache_req_complete_o,
  output logic                         uc_store_req_complete_o
);

  lce_cnt_t   cnt;
  logic       cnt_clear, cnt_inc, sync_done_clear, sync_done_set;
  lce_block_t data_buf;
  lce_stat_t  stat_buf;
  logic       data_buf_v, stat_buf_v;

  lce_cmd_fsm fsm (
    .*,
    .cnt_o(cnt),
    .cnt_clear_o(cnt_clear),
    .cnt_inc_o(cnt_inc),
    .sync_done_clear_o(sync_done_clear),
    .sync_done_set_o(sync_done_set),
    .data_buf_i(data_buf),
    .data_buf_v_i(data_buf_v),
    .stat_buf_i(stat_buf),
    .stat_buf_v_i(stat_buf_v)
  );

  lce_sweep_counter counter (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .cnt_clear_i(cnt_clear),
    .cnt_inc_i(cnt_inc),
    .sync_done_clear_i(sync_done_clear),
    .sync_done_set_i(sync_done_set),
    .cnt_o(cnt),
    .sync_done_o(sync_done_o)
  );

  // only accepted reads load a buffer
  lce_read_buf #(.payload_t(lce_block_t)) data_buf_u (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .read_accept_i(data_mem_yumi_i && (data_mem_op_o == e_data_read)),
    .rdata_i(data_mem_i),
    .buf_o(data_buf),
    .buf_v_o(data_buf_v)
  );

  lce_read_buf #(.payload_t(lce_stat_t)) stat_buf_u (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .read_accept_i(stat_mem_yumi_i && (stat_mem_op_o == e_stat_read)),
    .rdata_i(stat_mem_i),
    .buf_o(stat_buf),
    .buf_v_o(stat_buf_v)
  );

endmodule

// ==== sim/cache_mem_model.sv ====
// cache memory model
`include "lce_consts.svh"

module cache_mem_model
  import lce_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        tag_v_i,
  input  tag_op_e                     tag_op_i,
  input  logic [`LCE_INDEX_WIDTH-1:0] tag_index_i,
  input  logic [`LCE_WAY_WIDTH-1:0]   tag_way_i,
  input  coh_state_e                  tag_state_i,
  input  logic [`LCE_TAG_WIDTH-1:0]   tag_tag_i,
  output logic                        tag_yumi_o,
  input  logic                        stat_v_i,
  input  stat_op_e                    stat_op_i,
  input  logic [`LCE_INDEX_WIDTH-1:0] stat_index_i,
  input  logic [`LCE_WAY_WIDTH-1:0]   stat_way_i,
  output logic                        stat_yumi_o,
  output lce_stat_t                   stat_o,
  input  logic                        data_v_i,
  input  data_op_e                    data_op_i,
  input  logic [`LCE_INDEX_WIDTH-1:0] data_index_i,
  input  logic [`LCE_WAY_WIDTH-1:0]   data_way_i,
  input  lce_block_t                  data_data_i,
  output logic                        data_yumi_o,
  output lce_block_t                  data_o
);
  timeunit 1ns;
  timeprecision 1ps;

  coh_state_e                states [`LCE_SETS][`LCE_ASSOC];
  logic [`LCE_TAG_WIDTH-1:0] tags [`LCE_SETS][`LCE_ASSOC];
  lce_stat_t                 dirty [`LCE_SETS];
  lce_block_t                blocks [`LCE_SETS][`LCE_ASSOC];
  // accepted packets, fields a packet does not use are zeroed
  logic [127:0] tag_log[$];
  logic [127:0] stat_log[$];
  logic [127:0] data_log[$];
  logic       grant = 1'b0;
  logic       stat_pend = 1'b0;
  logic       data_pend = 1'b0;
  lce_stat_t  rd_stat;
  lce_block_t rd_blk;

  // one shared draw keeps paired packets accepted together
  assign tag_yumi_o  = tag_v_i & grant;
  assign stat_yumi_o = stat_v_i & grant;
  assign data_yumi_o = data_v_i & grant;

  initial begin
    stat_o = '0;
    data_o = '0;
  end

  task automatic load_line(input int s, input int w, input logic d, input lce_block_t b);
    dirty[s][w] = d;
    blocks[s][w] = b;
  endtask

  always @(posedge clk_i) begin
    #1;
    grant = $urandom_range(1, 0);
    // read data holds only for the cycle after the accept
    stat_o = stat_pend ? rd_stat : lce_stat_t'($urandom);
    data_o = data_pend ? rd_blk : {$urandom, $urandom};
    stat_pend = 1'b0;
    data_pend = 1'b0;
  end

  always @(negedge clk_i) begin
    if (tag_yumi_o) begin
      case (tag_op_i)
        e_tag_set_clear: begin
          tag_log.push_back({tag_op_i, tag_index_i, 1'b0, 3'b0, 11'b0});
          for (int w = 0; w < `LCE_ASSOC; w++) begin
            states[tag_index_i][w] = e_coh_i;
            tags[tag_index_i][w] = '0;
          end
        end
        e_tag_set_state: begin
          tag_log.push_back({tag_op_i, tag_index_i, tag_way_i, tag_state_i, 11'b0});
          states[tag_index_i][tag_way_i] = tag_state_i;
        end
        default: begin
          tag_log.push_back({tag_op_i, tag_index_i, tag_way_i, tag_state_i, tag_tag_i});
          states[tag_index_i][tag_way_i] = tag_state_i;
          tags[tag_index_i][tag_way_i] = tag_tag_i;
        end
      endcase
    end
    if (stat_yumi_o) begin
      stat_log.push_back((stat_op_i == e_stat_set_clear) ? {stat_op_i, stat_index_i, 1'b0}
                                                          : {stat_op_i, stat_index_i, stat_way_i});
      if (stat_op_i == e_stat_set_clear) dirty[stat_index_i] = '0;
      if (stat_op_i == e_stat_clear_dirty) dirty[stat_index_i][stat_way_i] = 1'b0;
      if (stat_op_i == e_stat_read) begin
        rd_stat = dirty[stat_index_i];
        stat_pend = 1'b1;
      end
    end
    if (data_yumi_o) begin
      if (data_op_i == e_data_write) begin
        data_log.push_back({data_op_i, data_index_i, data_way_i, data_data_i});
        blocks[data_index_i][data_way_i] = data_data_i;
      end else begin
        data_log.push_back({data_op_i, data_index_i, data_way_i, 64'b0});
        rd_blk = blocks[data_index_i][data_way_i];
        data_pend = 1'b1;
      end
    end
  end

endmodule

// ==== sim/lce_cmd_tb.sv ====
// lce command handler testbench
`include "lce_consts.svh"

module lce_cmd_tb
  import lce_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  logic clk_i = 1'b0;
  logic reset_i = 1'b1;
  logic lce_cmd_v_i = 1'b0;
  lce_cmd_type_e lce_cmd_type_i = e_cmd_sync;
  logic [15:0] lce_cmd_addr_i = '0;
  logic lce_cmd_src_id_i = 1'b0;
  logic lce_cmd_way_i = 1'b0;
  coh_state_e lce_cmd_state_i = e_coh_i;
  lce_block_t lce_cmd_data_i = '0;
  logic lce_resp_ready_i = 1'b0;
  logic lce_cmd_yumi_o, lce_resp_v_o;
  lce_resp_type_e lce_resp_type_o;
  logic [15:0] lce_resp_addr_o;
  logic lce_resp_dst_id_o;
  lce_block_t lce_resp_data_o, data_mem_data_o, data_mem_i;
  logic tag_mem_v_o, tag_mem_yumi_i, stat_mem_v_o, stat_mem_yumi_i, data_mem_v_o, data_mem_yumi_i;
  tag_op_e tag_mem_op_o;
  stat_op_e stat_mem_op_o;
  data_op_e data_mem_op_o;
  logic [1:0] tag_mem_index_o, stat_mem_index_o, data_mem_index_o;
  logic tag_mem_way_o, stat_mem_way_o, data_mem_way_o;
  coh_state_e tag_mem_state_o;
  logic [10:0] tag_mem_tag_o;
  lce_stat_t stat_mem_i;
  logic ready_o, sync_done_o, cache_req_complete_o, uc_store_req_complete_o;

  logic [127:0] exp_tag[$], exp_stat[$], exp_data[$], exp_resp[$];
  int n_cmds = 1;
  int cycles = 0;
  int cache_cnt = 0;
  int uc_cnt = 0;
  int sweep_cnt = 0;

  lce_cmd_top dut (.*);

  cache_mem_model mem (
    .clk_i(clk_i), .tag_v_i(tag_mem_v_o), .tag_op_i(tag_mem_op_o),
    .tag_index_i(tag_mem_index_o), .tag_way_i(tag_mem_way_o), .tag_state_i(tag_mem_state_o),
    .tag_tag_i(tag_mem_tag_o), .tag_yumi_o(tag_mem_yumi_i), .stat_v_i(stat_mem_v_o),
    .stat_op_i(stat_mem_op_o), .stat_index_i(stat_mem_index_o), .stat_way_i(stat_mem_way_o),
    .stat_yumi_o(stat_mem_yumi_i), .stat_o(stat_mem_i), .data_v_i(data_mem_v_o),
    .data_op_i(data_mem_op_o), .data_index_i(data_mem_index_o), .data_way_i(data_mem_way_o),
    .data_data_i(data_mem_data_o), .data_yumi_o(data_mem_yumi_i), .data_o(data_mem_i)
  );

  always #5 clk_i = ~clk_i;

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  endtask

  // expected response from the command and the line held by the model
  function automatic bit expected_resp(input lce_cmd_type_e t, input logic [15:0] addr,
                                       input logic src, input logic dirty, input lce_block_t blk,
                                       output lce_resp_type_e rt, output logic dst,
                                       output logic [15:0] raddr, output lce_block_t rdata);
    expected_resp = 1'b1;
    rt = e_resp_sync_ack;
    dst = src;
    raddr = addr;
    rdata = '0;
    case (t)
      e_cmd_sync: rt = e_resp_sync_ack;
      e_cmd_inv: rt = e_resp_inv_ack;
      e_cmd_data, e_cmd_st_wakeup: rt = e_resp_coh_ack;
      e_cmd_wb, e_cmd_st_wb: begin
        rt = dirty ? e_resp_wb : e_resp_null_wb;
        rdata = dirty ? blk : '0;
      end
      default: expected_resp = 1'b0;
    endcase
  endfunction

  // response and completion checks mid cycle
  always @(negedge clk_i) begin
    logic [127:0] e;
    if (lce_resp_v_o) begin
      if (!lce_resp_ready_i) stop_run("response valid while ready was low");
      if (exp_resp.size() == 0) stop_run("response sent with none expected");
      e = exp_resp.pop_front();
      check_val("lce_resp_type_o", lce_resp_type_o, e[83:81]);
      check_val("lce_resp_dst_id_o", lce_resp_dst_id_o, e[80]);
      check_val("lce_resp_addr_o", lce_resp_addr_o, e[79:64]);
      if (lce_resp_type_o == e_resp_wb) check_val("lce_resp_data_o", lce_resp_data_o, e[63:0]);
    end
    if (cache_req_complete_o) begin
      check_val("lce_cmd_yumi_o", lce_cmd_yumi_o, 1);
      cache_cnt++;
    end
    if (uc_store_req_complete_o) begin
      check_val("lce_cmd_yumi_o", lce_cmd_yumi_o, 1);
      uc_cnt++;
    end
    if (!ready_o && tag_mem_v_o && tag_mem_yumi_i) sweep_cnt++;
    if (ready_o && sweep_cnt < `LCE_SETS) stop_run("ready raised before the sweep finished");
  end

  // packets logged by the model
  always @(posedge clk_i) begin
    while (mem.tag_log.size() > 0) begin
      if (exp_tag.size() == 0) stop_run("unexpected tag memory packet");
      check_val("tag_mem packet", mem.tag_log.pop_front(), exp_tag.pop_front());
    end
    while (mem.stat_log.size() > 0) begin
      if (exp_stat.size() == 0) stop_run("unexpected stat memory packet");
      check_val("stat_mem packet", mem.stat_log.pop_front(), exp_stat.pop_front());
    end
    while (mem.data_log.size() > 0) begin
      if (exp_data.size() == 0) stop_run("unexpected data memory packet");
      check_val("data_mem packet", mem.data_log.pop_front(), exp_data.pop_front());
    end
  end

  always @(posedge clk_i) begin
    #1;
    lce_resp_ready_i = ($urandom_range(3, 0) != 0);
  end

  // watchdog
  always @(posedge clk_i) begin
    cycles++;
    if (cycles > 200 * n_cmds + 50) stop_run("timeout, the DUT stopped making progress");
  end

  task automatic run_cmd(input lce_cmd_type_e t, input logic [15:0] addr, input logic src,
                         input logic way, input coh_state_e st, input lce_block_t d);
    logic [1:0] idx;
    logic [10:0] tg;
    logic dirty, dst;
    lce_block_t blk, rd;
    lce_resp_type_e rt;
    logic [15:0] ra;
    int cache_before, uc_before;
    idx = addr[4:3];
    tg = addr[15:5];
    dirty = mem.dirty[idx][way];
    blk = mem.blocks[idx][way];
    case (t)
      e_cmd_set_clear: begin
        exp_tag.push_back({e_tag_set_clear, idx, 1'b0, 3'b0, 11'b0});
        exp_stat.push_back({e_stat_set_clear, idx, 1'b0});
      end
      e_cmd_inv: exp_tag.push_back({e_tag_set_state, idx, way, e_coh_i, 11'b0});
      e_cmd_st, e_cmd_st_wakeup: exp_tag.push_back({e_tag_set_state, idx, way, st, 11'b0});
      e_cmd_data: begin
        exp_data.push_back({e_data_write, idx, way, d});
        exp_tag.push_back({e_tag_set_tag, idx, way, st, tg});
      end
      e_cmd_wb, e_cmd_st_wb: begin
        if (t == e_cmd_st_wb) exp_tag.push_back({e_tag_set_state, idx, way, st, 11'b0});
        exp_stat.push_back({e_stat_read, idx, way});
        if (dirty) begin
          exp_data.push_back({e_data_read, idx, way, 64'b0});
          exp_stat.push_back({e_stat_clear_dirty, idx, way});
        end
      end
      default: begin
      end
    endcase
    if (expected_resp(t, addr, src, dirty, blk, rt, dst, ra, rd)) begin
      exp_resp.push_back({rt, dst, ra, rd});
    end
    n_cmds++;
    cache_before = cache_cnt;
    uc_before = uc_cnt;
    @(posedge clk_i);
    #1;
    lce_cmd_type_i = t;
    lce_cmd_addr_i = addr;
    lce_cmd_src_id_i = src;
    lce_cmd_way_i = way;
    lce_cmd_state_i = st;
    lce_cmd_data_i = d;
    lce_cmd_v_i = 1'b1;
    do @(negedge clk_i); while (!lce_cmd_yumi_o);
    @(posedge clk_i);
    #1;
    lce_cmd_v_i = 1'b0;
    check_val("pending tag packets", exp_tag.size(), 0);
    check_val("pending stat packets", exp_stat.size(), 0);
    check_val("pending data packets", exp_data.size(), 0);
    check_val("pending responses", exp_resp.size(), 0);
    check_val("cache_req_complete_o pulses", cache_cnt - cache_before,
              (t == e_cmd_data || t == e_cmd_st_wakeup) ? 1 : 0);
    check_val("uc_store_req_complete_o pulses", uc_cnt - uc_before, (t == e_cmd_uc_st_done) ? 1 : 0);
  endtask

  initial begin
    void'($urandom(39));
    for (int i = 0; i < `LCE_SETS; i++) begin
      exp_tag.push_back({e_tag_set_clear, 2'(i), 1'b0, 3'b0, 11'b0});
      exp_stat.push_back({e_stat_set_clear, 2'(i), 1'b0});
    end
    // control outputs stay low in reset and the cycle after
    for (int i = 0; i < 3; i++) begin
      if (i == 2) begin
        @(posedge clk_i);
        #1;
        reset_i = 1'b0;
      end
      @(negedge clk_i);
      check_val("control outputs", {ready_o, sync_done_o, tag_mem_v_o, stat_mem_v_o, data_mem_v_o,
                lce_resp_v_o, lce_cmd_yumi_o, cache_req_complete_o, uc_store_req_complete_o}, 0);
    end
    while (!ready_o) @(negedge clk_i);
    check_val("sweep packets left", exp_tag.size() + exp_stat.size(), 0);
    for (int s = 0; s < `LCE_SETS; s++) begin
      for (int w = 0; w < `LCE_ASSOC; w++) begin
        mem.load_line(s, w, logic'((s + w) % 2), {$urandom, $urandom});
      end
    end
    run_cmd(e_cmd_sync, 16'h0000, 1'b0, 1'b0, e_coh_i, '0);
    check_val("sync_done_o", sync_done_o, 0);
    run_cmd(e_cmd_sync, 16'h0000, 1'b1, 1'b0, e_coh_i, '0);
    check_val("sync_done_o", sync_done_o, 1);
    run_cmd(e_cmd_set_clear, 16'h1a48, 1'b0, 1'b0, e_coh_s, '0);
    run_cmd(e_cmd_inv, 16'h3310, 1'b1, 1'b1, e_coh_m, '0);
    run_cmd(e_cmd_st, 16'h0408, 1'b0, 1'b0, e_coh_e, '0);
    run_cmd(e_cmd_data, 16'hbee0, 1'b1, 1'b0, e_coh_m, {$urandom, $urandom});
    run_cmd(e_cmd_st_wakeup, 16'h7f18, 1'b0, 1'b1, e_coh_s, '0);
    for (int i = 0; i < 8; i++) begin
      run_cmd((i % 2) ? e_cmd_st_wb : e_cmd_wb, {11'($urandom), 2'(i / 2), 3'b0}, 1'(i),
              1'(i / 4 + i), e_coh_s, '0);
    end
    run_cmd(e_cmd_uc_st_done, 16'h0050, 1'b1, 1'b0, e_coh_i, '0);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== lce_cmd_top.f ====
+incdir+include
design/lce_pkg.sv
design/lce_read_buf.sv
design/lce_sweep_counter.sv
design/lce_cmd_fsm.sv
design/lce_cmd_top.sv
sim/cache_mem_model.sv
sim/lce_cmd_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = lce_cmd_tb
FILELIST = lce_cmd_top.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
